// File: design/strm_pkg.sv
`default_nettype none

package strm_pkg;

  // Stream geometry
  localparam int num_ch  = 2;
  localparam int data_w  = 32;
  localparam int len_w   = 4;
  localparam int delay_w = 8;
  localparam int cnt_w   = 16;

  // APB register map, byte addresses
  localparam logic [7:0] addr_ctrl = 8'h00;
  localparam logic [7:0] addr_cfg0 = 8'h04;
  localparam logic [7:0] addr_cfg1 = 8'h08;
  localparam logic [7:0] addr_cnt0 = 8'h0C;
  localparam logic [7:0] addr_cnt1 = 8'h10;

  typedef logic [data_w-1:0]          strm_data_t;
  typedef logic [len_w-1:0]           strm_len_t;
  typedef logic [delay_w-1:0]         strm_delay_t;
  typedef logic [cnt_w-1:0]           strm_cnt_t;
  typedef logic [$clog2(num_ch)-1:0]  strm_ch_t;

  // Per-channel settings as seen by a source
  typedef struct packed {
    logic        en;
    strm_delay_t delay;
    strm_len_t   len;
  } ch_cfg_t;

  // One stream word with its end-of-packet marker
  typedef struct packed {
    strm_data_t data;
    logic       last;
  } strm_beat_t;

  typedef enum logic [1:0] {
    idle,
    wait_delay,
    send
  } src_state_e;

endpackage

`default_nettype wire

// File: design/strm_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module strm_cfg_regs (
  input  logic                 M_AXIS_ACLK,
  input  logic                 M_AXIS_ARESETN,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [7:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pslverr,
  output strm_pkg::ch_cfg_t    cfg0,
  output strm_pkg::ch_cfg_t    cfg1,
  input  logic                 pkt_done0,
  input  logic                 pkt_done1
);

  logic                access;
  logic                mapped;
  logic                wr_ok;
  logic                wr_en;
  logic [31:0]         rd_data;
  strm_pkg::strm_cnt_t cnt0_q;
  strm_pkg::strm_cnt_t cnt1_q;
  strm_pkg::strm_delay_t wr_delay;
  strm_pkg::strm_len_t   wr_len;

  assign access   = psel && penable;
  assign wr_delay = pwdata[strm_pkg::delay_w-1:0];
  assign wr_len   = pwdata[strm_pkg::delay_w +: strm_pkg::len_w];

  // Address decode, read mux and write legality
  always_comb begin
    mapped  = 1'b1;
    wr_ok   = 1'b0;
    rd_data = '0;
    case (paddr)
      strm_pkg::addr_ctrl: begin
        rd_data = 32'({cfg1.en, cfg0.en});
        wr_ok   = 1'b1;
      end
      strm_pkg::addr_cfg0: begin
        rd_data = 32'({cfg0.len, cfg0.delay});
        wr_ok   = (wr_len != '0);
      end
      strm_pkg::addr_cfg1: begin
        rd_data = 32'({cfg1.len, cfg1.delay});
        wr_ok   = (wr_len != '0);
      end
      strm_pkg::addr_cnt0: rd_data = 32'(cnt0_q);
      strm_pkg::addr_cnt1: rd_data = 32'(cnt1_q);
      default:             mapped  = 1'b0;
    endcase
  end

  assign prdata  = rd_data;
  assign pslverr = access && (!mapped || (pwrite && !wr_ok));
  assign wr_en   = access && pwrite && wr_ok;

  // Channels come up disabled with delay 0 and a one-word packet
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      cfg0 <= '{en: 1'b0, delay: '0, len: strm_pkg::strm_len_t'(1)};
      cfg1 <= '{en: 1'b0, delay: '0, len: strm_pkg::strm_len_t'(1)};
    end else if (wr_en) begin
      case (paddr)
        strm_pkg::addr_ctrl: begin
          cfg0.en <= pwdata[0];
          cfg1.en <= pwdata[1];
        end
        strm_pkg::addr_cfg0: begin
          cfg0.delay <= wr_delay;
          cfg0.len   <= wr_len;
        end
        strm_pkg::addr_cfg1: begin
          cfg1.delay <= wr_delay;
          cfg1.len   <= wr_len;
        end
        default: ;
      endcase
    end
  end

  // Completed packets per channel, wrapping
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      cnt0_q <= '0;
      cnt1_q <= '0;
    end else begin
      if (pkt_done0) cnt0_q <= cnt0_q + 1'b1;
      if (pkt_done1) cnt1_q <= cnt1_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/strm_pkt_source.sv
`timescale 1ns/1ps
`default_nettype none

module strm_pkt_source #(
  parameter strm_pkg::strm_ch_t ch_id = '0
) (
  input  logic                  M_AXIS_ACLK,
  input  logic                  M_AXIS_ARESETN,
  input  strm_pkg::ch_cfg_t     cfg,
  output logic                  src_valid,
  output strm_pkg::strm_beat_t  src_beat,
  input  logic                  src_ready,
  output logic                  pkt_done
);

  strm_pkg::src_state_e  state_q;
  strm_pkg::strm_delay_t delay_q;
  strm_pkg::strm_delay_t delay_cnt_q;
  strm_pkg::strm_len_t   len_q;
  strm_pkg::strm_len_t   word_idx_q;
  strm_pkg::strm_cnt_t   seq_q;
  strm_pkg::strm_data_t  data_q;
  logic                  valid_q;
  logic                  last_q;
  logic                  xfer;
  logic                  load;

  assign xfer = valid_q && src_ready;

  // Fetch the next word when the output register is empty or just drained
  assign load = (state_q == strm_pkg::send) && (!valid_q || (xfer && !last_q));

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state_q     <= strm_pkg::idle;
      delay_cnt_q <= '0;
      word_idx_q  <= '0;
      seq_q       <= '0;
      valid_q     <= 1'b0;
      last_q      <= 1'b0;
    end else begin
      case (state_q)
        strm_pkg::idle: begin
          if (cfg.en) begin
            state_q     <= strm_pkg::wait_delay;
            delay_cnt_q <= '0;
            word_idx_q  <= '0;
          end
        end
        strm_pkg::wait_delay: begin
          if (delay_cnt_q == delay_q) begin
            state_q <= strm_pkg::send;
          end else begin
            delay_cnt_q <= delay_cnt_q + 1'b1;
          end
        end
        strm_pkg::send: begin
          if (xfer && last_q) begin
            state_q <= strm_pkg::idle;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            seq_q   <= seq_q + 1'b1;
          end else if (load) begin
            valid_q    <= 1'b1;
            last_q     <= (word_idx_q == strm_pkg::strm_len_t'(len_q - 1'b1));
            word_idx_q <= word_idx_q + 1'b1;
          end
        end
        default: state_q <= strm_pkg::idle;
      endcase
    end
  end

  // Settings are frozen for the whole packet
  always_ff @(posedge M_AXIS_ACLK) begin
    if (state_q == strm_pkg::idle && cfg.en) begin
      delay_q <= cfg.delay;
      len_q   <= cfg.len;
    end
  end

  // Channel, sequence number, word number
  always_ff @(posedge M_AXIS_ACLK) begin
    if (load) begin
      data_q <= {8'(ch_id), seq_q, 8'(word_idx_q) + 8'd1};
    end
  end

  assign src_valid = valid_q;
  assign src_beat  = '{data: data_q, last: last_q};
  assign pkt_done  = xfer && last_q;

endmodule

`default_nettype wire

// File: design/strm_pkt_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module strm_pkt_arbiter (
  input  logic                  M_AXIS_ACLK,
  input  logic                  M_AXIS_ARESETN,
  input  logic                  src0_valid,
  input  strm_pkg::strm_beat_t  src0_beat,
  input  logic                  src1_valid,
  input  strm_pkg::strm_beat_t  src1_beat,
  output logic                  src0_ready,
  output logic                  src1_ready,
  output logic                  out_valid,
  output strm_pkg::strm_beat_t  out_beat,
  input  logic                  out_ready
);

  strm_pkg::strm_ch_t grant_q;
  strm_pkg::strm_ch_t sel;
  logic               open_q;

  // Channel picked for this cycle, locked while a packet is open
  always_comb begin
    if (open_q) begin
      sel = grant_q;
    end else if (src0_valid && src1_valid) begin
      sel = ~grant_q;
    end else if (src1_valid) begin
      sel = 1'b1;
    end else if (src0_valid) begin
      sel = 1'b0;
    end else begin
      sel = grant_q;
    end
  end

  assign out_valid  = (sel == 1'b1) ? src1_valid : src0_valid;
  assign out_beat   = (sel == 1'b1) ? src1_beat : src0_beat;
  assign src0_ready = out_ready && (sel == 1'b0);
  assign src1_ready = out_ready && (sel == 1'b1);

  // A presented beat opens the packet so a stalled beat keeps its channel
  // until the TLAST transfer releases it
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      grant_q <= 1'b1;
      open_q  <= 1'b0;
    end else if (out_valid) begin
      grant_q <= sel;
      open_q  <= !(out_ready && out_beat.last);
    end
  end

endmodule

`default_nettype wire

// File: design/strm_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module strm_gen_top (
  input  logic                  M_AXIS_ACLK,
  input  logic                  M_AXIS_ARESETN,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pslverr,
  output logic                  m_axis_tvalid,
  output strm_pkg::strm_data_t  m_axis_tdata,
  output logic                  m_axis_tlast,
  input  logic                  m_axis_tready
);

  strm_pkg::ch_cfg_t    cfg0;
  strm_pkg::ch_cfg_t    cfg1;
  strm_pkg::strm_beat_t src0_beat;
  strm_pkg::strm_beat_t src1_beat;
  strm_pkg::strm_beat_t arb_beat;
  logic                 src0_valid;
  logic                 src1_valid;
  logic                 src0_ready;
  logic                 src1_ready;
  logic                 pkt_done0;
  logic                 pkt_done1;

  strm_cfg_regs u_regs (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pslverr        (pslverr),
    .cfg0           (cfg0),
    .cfg1           (cfg1),
    .pkt_done0      (pkt_done0),
    .pkt_done1      (pkt_done1)
  );

  strm_pkt_source #(.ch_id(1'b0)) u_src0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cfg            (cfg0),
    .src_valid      (src0_valid),
    .src_beat       (src0_beat),
    .src_ready      (src0_ready),
    .pkt_done       (pkt_done0)
  );

  strm_pkt_source #(.ch_id(1'b1)) u_src1 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cfg            (cfg1),
    .src_valid      (src1_valid),
    .src_beat       (src1_beat),
    .src_ready      (src1_ready),
    .pkt_done       (pkt_done1)
  );

  strm_pkt_arbiter u_arb (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .src0_valid     (src0_valid),
    .src0_beat      (src0_beat),
    .src1_valid     (src1_valid),
    .src1_beat      (src1_beat),
    .src0_ready     (src0_ready),
    .src1_ready     (src1_ready),
    .out_valid      (m_axis_tvalid),
    .out_beat       (arb_beat),
    .out_ready      (m_axis_tready)
  );

  assign m_axis_tdata = arb_beat.data;
  assign m_axis_tlast = arb_beat.last;

endmodule

`default_nettype wire

// File: tb/strm_gen_chk.sv
`timescale 1ns/1ps
`default_nettype none

module strm_gen_chk (
  input logic                 M_AXIS_ACLK,
  input logic                 M_AXIS_ARESETN,
  input logic                 psel,
  input logic                 penable,
  input logic                 pslverr,
  input logic                 m_axis_tvalid,
  input strm_pkg::strm_data_t m_axis_tdata,
  input logic                 m_axis_tlast,
  input logic                 m_axis_tready
);

  int fail_count = 0;

  // Beat held while the sink stalls
  assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      $error("stream beat changed or dropped while stalled");
      fail_count++;
    end

  assert property (@(posedge M_AXIS_ACLK) $rose(M_AXIS_ARESETN) |-> !m_axis_tvalid)
    else begin
      $error("m_axis_tvalid high in the first cycle after reset");
      fail_count++;
    end

  assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    pslverr |-> psel && penable)
    else begin
      $error("pslverr raised outside an access phase");
      fail_count++;
    end

  assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    m_axis_tlast |-> m_axis_tvalid)
    else begin
      $error("m_axis_tlast high without m_axis_tvalid");
      fail_count++;
    end

endmodule

bind strm_gen_top strm_gen_chk u_chk (.*);

`default_nettype wire

// File: tb/strm_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module strm_gen_tb;

  // Columns en0 en1 delay0 len0 delay1 len1 packets per channel and alternation check
  typedef struct packed {
    logic                  en0;
    logic                  en1;
    strm_pkg::strm_delay_t delay0;
    strm_pkg::strm_len_t   len0;
    strm_pkg::strm_delay_t delay1;
    strm_pkg::strm_len_t   len1;
    logic [7:0]            pkts;
    logic                  alt;
  } row_t;

  logic                 M_AXIS_ACLK;
  logic                 M_AXIS_ARESETN;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [7:0]           paddr;
  logic [31:0]          pwdata;
  logic [31:0]          prdata;
  logic                 pslverr;
  logic                 m_axis_tvalid;
  strm_pkg::strm_data_t m_axis_tdata;
  logic                 m_axis_tlast;
  logic                 m_axis_tready;

  row_t rows [6];
  int   seed = 61442;
  int   value_errs = 0;
  int   other_errs = 0;
  int   cycles = 0;
  int   cycle_limit = 0;
  int   seen [2] = '{0, 0};
  int   exp_len [2] = '{1, 1};
  int   last_ch = -1;
  bit   alt_check = 1'b0;
  bit   in_pkt = 1'b0;
  int   cur_ch = 0;
  int   word_idx = 0;

  strm_gen_top u_dut (.*);

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #2 M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  // Sink stalls about one beat in four
  always @(posedge M_AXIS_ACLK) begin
    #1 m_axis_tready = ($random(seed) & 3) != 0;
  end

  function automatic void compare_value(input string name, input logic [31:0] expected,
                                        input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errs++;
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endfunction

  function automatic void check_condition(input bit ok, input string what);
    assert (ok) else begin
      other_errs++;
      $display("Error at %0t: %s", $time, what);
    end
  endfunction

  function automatic void report_counts();
    $display("Errors: %0d wrong values, %0d other failures, %0d protocol assertions",
             value_errs, other_errs, u_dut.u_chk.fail_count);
  endfunction

  // Delay in bits 7:0, length in bits 11:8
  function automatic logic [31:0] cfg_word(input strm_pkg::strm_delay_t delay,
                                           input strm_pkg::strm_len_t len);
    return {20'd0, len, delay};
  endfunction

  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge M_AXIS_ACLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge M_AXIS_ACLK);
    #1 penable = 1'b1;
    // Sampled mid access phase
    #1;
    rdata = prdata;
    err   = pslverr;
    @(posedge M_AXIS_ACLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic        err;
    logic [31:0] rd;
    bus_access(1'b1, addr, data, rd, err);
    compare_value("pslverr", 0, err);
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr,
                             input logic [31:0] expected);
    logic        err;
    logic [31:0] rd;
    bus_access(1'b0, addr, 32'd0, rd, err);
    compare_value("pslverr", 0, err);
    compare_value(name, expected, rd);
  endtask

  task automatic check_register_errors();
    logic        err;
    logic [31:0] rd;
    write_ok(strm_pkg::addr_cfg0, cfg_word(8'd9, 4'd5));
    bus_access(1'b1, strm_pkg::addr_cfg0, cfg_word(8'd3, 4'd0), rd, err);
    compare_value("pslverr on zero length", 1, err);
    bus_access(1'b1, strm_pkg::addr_cnt0, 32'h1234, rd, err);
    compare_value("pslverr on CNT0 write", 1, err);
    bus_access(1'b1, 8'h40, 32'h3, rd, err);
    compare_value("pslverr on unmapped write", 1, err);
    bus_access(1'b0, 8'h40, 32'h0, rd, err);
    compare_value("pslverr on unmapped read", 1, err);
    read_expect("CFG0", strm_pkg::addr_cfg0, cfg_word(8'd9, 4'd5));
    read_expect("CFG1", strm_pkg::addr_cfg1, cfg_word(8'd0, 4'd1));
    read_expect("CNT0", strm_pkg::addr_cnt0, 32'd0);
    read_expect("CTRL", strm_pkg::addr_ctrl, 32'd0);
  endtask

  task automatic run_row(input row_t r);
    int start0;
    int start1;
    int quiet;
    int idle_run;
    write_ok(strm_pkg::addr_cfg0, cfg_word(r.delay0, r.len0));
    write_ok(strm_pkg::addr_cfg1, cfg_word(r.delay1, r.len1));
    read_expect("CFG0", strm_pkg::addr_cfg0, cfg_word(r.delay0, r.len0));
    read_expect("CFG1", strm_pkg::addr_cfg1, cfg_word(r.delay1, r.len1));
    exp_len[0] = r.len0;
    exp_len[1] = r.len1;
    start0     = seen[0];
    start1     = seen[1];
    // Equal settings start both channels together, so the first grant
    // goes to the channel not served last
    alt_check  = r.alt;
    write_ok(strm_pkg::addr_ctrl, {30'd0, r.en1, r.en0});
    while ((r.en0 && seen[0] - start0 < r.pkts) || (r.en1 && seen[1] - start1 < r.pkts)) begin
      @(posedge M_AXIS_ACLK);
    end
    alt_check = 1'b0;
    write_ok(strm_pkg::addr_ctrl, 32'd0);
    // A source already past idle still finishes its packet
    quiet    = (r.delay0 > r.delay1 ? r.delay0 : r.delay1) + 8;
    idle_run = 0;
    while (idle_run < quiet) begin
      @(negedge M_AXIS_ACLK);
      idle_run = m_axis_tvalid ? 0 : idle_run + 1;
    end
    check_condition(r.en0 || seen[0] == start0, "channel 0 sent packets while disabled");
    check_condition(r.en1 || seen[1] == start1, "channel 1 sent packets while disabled");
    read_expect("CNT0", strm_pkg::addr_cnt0, seen[0] % 65536);
    read_expect("CNT1", strm_pkg::addr_cnt1, seen[1] % 65536);
  endtask

  // Scoreboard on beats that transfer at the next rising edge
  always @(negedge M_AXIS_ACLK) begin
    if (M_AXIS_ARESETN && m_axis_tvalid && m_axis_tready) begin
      if (!in_pkt) begin
        check_condition(m_axis_tdata[31:24] < 2, "packet opened with an unknown channel index");
        cur_ch = m_axis_tdata[24];
        check_condition(!alt_check || last_ch != cur_ch, "a channel sent two packets in a row");
        in_pkt   = 1'b1;
        word_idx = 0;
      end
      compare_value("m_axis_tdata[31:24]", cur_ch, m_axis_tdata[31:24]);
      compare_value("m_axis_tdata[23:8]", seen[cur_ch] % 65536, m_axis_tdata[23:8]);
      compare_value("m_axis_tdata[7:0]", word_idx + 1, m_axis_tdata[7:0]);
      compare_value("m_axis_tlast", word_idx == exp_len[cur_ch] - 1, m_axis_tlast);
      if (m_axis_tlast) begin
        in_pkt = 1'b0;
        seen[cur_ch]++;
        last_ch = cur_ch;
      end else begin
        word_idx++;
      end
    end
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge M_AXIS_ACLK);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles", cycle_limit);
    report_counts();
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    M_AXIS_ARESETN = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    m_axis_tready  = 1'b0;
    // Single channels first, then both with equal and unequal settings
    rows[0] = '{1'b1, 1'b0, 8'd3, 4'd5, 8'd0, 4'd1, 8'd6, 1'b0};
    rows[1] = '{1'b0, 1'b1, 8'd0, 4'd1, 8'd0, 4'd15, 8'd4, 1'b0};
    rows[2] = '{1'b1, 1'b1, 8'd2, 4'd4, 8'd2, 4'd4, 8'd8, 1'b1};
    rows[3] = '{1'b1, 1'b1, 8'd0, 4'd1, 8'd0, 4'd1, 8'd10, 1'b1};
    rows[4] = '{1'b1, 1'b1, 8'd5, 4'd15, 8'd1, 4'd3, 8'd5, 1'b0};
    rows[5] = '{1'b1, 1'b1, 8'd10, 4'd7, 8'd10, 4'd7, 8'd4, 1'b1};
    cycle_limit = 5000;
    foreach (rows[i]) begin
      cycle_limit += rows[i].en0 * rows[i].pkts * (rows[i].delay0 + rows[i].len0 + 4) * 4;
      cycle_limit += rows[i].en1 * rows[i].pkts * (rows[i].delay1 + rows[i].len1 + 4) * 4;
    end
    repeat (3) @(posedge M_AXIS_ACLK);
    #1 M_AXIS_ARESETN = 1'b1;
    check_register_errors();
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    report_counts();
    if (value_errs + other_errs + u_dut.u_chk.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
design/strm_pkg.sv
design/strm_cfg_regs.sv
design/strm_pkt_source.sv
design/strm_pkt_arbiter.sv
design/strm_gen_top.sv
tb/strm_gen_chk.sv
tb/strm_gen_tb.sv

// File: Bender.yml
package:
  name: strm_gen

sources:
  - design/strm_pkg.sv
  - design/strm_cfg_regs.sv
  - design/strm_pkt_source.sv
  - design/strm_pkt_arbiter.sv
  - design/strm_gen_top.sv
  - target: test
    files:
      - tb/strm_gen_chk.sv
      - tb/strm_gen_tb.sv
